// File: logic/mem_pkg.sv
`default_nettype none

package mem_pkg;

	localparam int NUM_PORTS = 2; // user ports with one bridge each.
	localparam int ADDR_WIDTH = 32;
	localparam int DATA_WIDTH = 32;
	localparam int SEL_WIDTH = 4;

	localparam int MEM_WORDS = 256;
	localparam int WORD_BITS = 8; // log2 of MEM_WORDS.

	typedef enum logic {
		ARB_IDLE,
		ARB_BUSY
	} arb_state_t;

	typedef enum logic {
		MEM_CLEAR, // zero sweep after reset.
		MEM_READY
	} mem_state_t;

endpackage

`default_nettype wire

// File: logic/wb_classic_if.sv
`default_nettype none

interface wb_classic_if;

	logic [mem_pkg::ADDR_WIDTH-1:0] adr;
	logic [mem_pkg::DATA_WIDTH-1:0] dat_w;
	logic [mem_pkg::DATA_WIDTH-1:0] dat_r;
	logic [mem_pkg::SEL_WIDTH-1:0]  sel;
	logic                           we;
	logic                           cyc;
	logic                           stb;
	logic                           ack; // one-cycle pulse.
	logic                           err;

	modport master (
		output adr, dat_w, sel, we, cyc, stb,
		input  dat_r, ack, err
	);

	modport slave (
		input  adr, dat_w, sel, we, cyc, stb,
		output dat_r, ack, err
	);

endinterface

`default_nettype wire

// File: logic/port_bridge.sv
`default_nettype none

module port_bridge (
	input  logic                           clk,
	input  logic                           rst,
	input  logic [mem_pkg::ADDR_WIDTH-1:0] in_adr,
	input  logic [mem_pkg::DATA_WIDTH-1:0] in_dat_w,
	input  logic [mem_pkg::SEL_WIDTH-1:0]  in_sel,
	input  logic                           in_we,
	input  logic                           in_cyc,
	input  logic                           in_stb,
	output logic                           stall,
	output logic                           ack,
	output logic                           err,
	output logic [mem_pkg::DATA_WIDTH-1:0] dat_r,
	wb_classic_if.master                   bus
);

	logic                           pending;
	logic [mem_pkg::ADDR_WIDTH-1:0] adr_q;
	logic [mem_pkg::DATA_WIDTH-1:0] dat_w_q;
	logic [mem_pkg::SEL_WIDTH-1:0]  sel_q;
	logic                           we_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			pending <= 1'b0;
		end else if (!pending) begin
			if (in_stb) pending <= 1'b1; // accept one request.
		end else if (bus.ack || bus.err) begin
			pending <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (!pending && in_stb) begin
			adr_q   <= in_adr;
			dat_w_q <= in_dat_w;
			sel_q   <= in_sel;
			we_q    <= in_we;
		end
	end

	assign bus.adr   = adr_q;
	assign bus.dat_w = dat_w_q;
	assign bus.sel   = sel_q;
	assign bus.we    = we_q;
	assign bus.stb   = pending;
	assign bus.cyc   = in_cyc;

	assign stall = pending; // back-pressure while outstanding.
	assign ack   = bus.ack;
	assign err   = bus.err;
	assign dat_r = bus.dat_r;

endmodule

`default_nettype wire

// File: logic/port_arbiter.sv
`default_nettype none

module port_arbiter (
	input  logic         clk,
	input  logic         rst,
	input  logic         init_done,
	wb_classic_if.slave  ports [mem_pkg::NUM_PORTS],
	wb_classic_if.master core
);

	mem_pkg::arb_state_t state;

	logic [$clog2(mem_pkg::NUM_PORTS)-1:0] grant;
	logic [$clog2(mem_pkg::NUM_PORTS)-1:0] last;
	logic [$clog2(mem_pkg::NUM_PORTS)-1:0] next_grant;
	logic                                  found;
	logic                                  busy;

	logic [mem_pkg::NUM_PORTS-1:0]  req;
	logic [mem_pkg::NUM_PORTS-1:0]  cyc_v;
	logic [mem_pkg::NUM_PORTS-1:0]  stb_v;
	logic [mem_pkg::NUM_PORTS-1:0]  we_v;
	logic [mem_pkg::ADDR_WIDTH-1:0] adr_v   [mem_pkg::NUM_PORTS];
	logic [mem_pkg::DATA_WIDTH-1:0] dat_w_v [mem_pkg::NUM_PORTS];
	logic [mem_pkg::SEL_WIDTH-1:0]  sel_v   [mem_pkg::NUM_PORTS];

	assign busy = (state == mem_pkg::ARB_BUSY);

	for (genvar i = 0; i < mem_pkg::NUM_PORTS; i++) begin : g_port
		assign cyc_v[i]   = ports[i].cyc;
		assign stb_v[i]   = ports[i].stb;
		assign we_v[i]    = ports[i].we;
		assign adr_v[i]   = ports[i].adr;
		assign dat_w_v[i] = ports[i].dat_w;
		assign sel_v[i]   = ports[i].sel;
		assign req[i]     = ports[i].cyc && ports[i].stb;

		// only the granted bridge sees the response.
		assign ports[i].ack   = busy && (grant == i) && core.ack;
		assign ports[i].err   = busy && (grant == i) && core.err;
		assign ports[i].dat_r = core.dat_r;
	end

	// search starts just after the last port served.
	always_comb begin
		int idx;
		found = 1'b0;
		next_grant = last;
		for (int k = 1; k <= mem_pkg::NUM_PORTS; k++) begin
			idx = (int'(last) + k) % mem_pkg::NUM_PORTS;
			if (!found && req[idx]) begin
				found = 1'b1;
				next_grant = idx[$clog2(mem_pkg::NUM_PORTS)-1:0];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= mem_pkg::ARB_IDLE;
			grant <= '0;
			last  <= '0;
		end else begin
			case (state)
				mem_pkg::ARB_IDLE: if (init_done && found) begin
					grant <= next_grant;
					state <= mem_pkg::ARB_BUSY;
				end
				mem_pkg::ARB_BUSY: if (core.ack || core.err) begin
					last  <= grant;
					state <= mem_pkg::ARB_IDLE;
				end
				default: state <= mem_pkg::ARB_IDLE;
			endcase
		end
	end

	assign core.adr   = adr_v[grant];
	assign core.dat_w = dat_w_v[grant];
	assign core.sel   = sel_v[grant];
	assign core.we    = we_v[grant];
	assign core.cyc   = busy && cyc_v[grant];
	assign core.stb   = busy && stb_v[grant];

endmodule

`default_nettype wire

// File: logic/mem_core.sv
`default_nettype none

module mem_core (
	input  logic        clk,
	input  logic        rst,
	output logic        init_done,
	wb_classic_if.slave bus
);

	mem_pkg::mem_state_t state;

	logic [mem_pkg::DATA_WIDTH-1:0] mem [mem_pkg::MEM_WORDS];
	logic [mem_pkg::WORD_BITS-1:0]  clr_cnt;
	logic [mem_pkg::WORD_BITS-1:0]  word_idx;
	logic                           in_range;
	logic                           req;

	assign word_idx = bus.adr[mem_pkg::WORD_BITS+1:2];
	assign in_range = (bus.adr[mem_pkg::ADDR_WIDTH-1:mem_pkg::WORD_BITS+2] == '0);

	// a new request; the cycle carrying ack or err is not served again.
	assign req = (state == mem_pkg::MEM_READY) && bus.cyc && bus.stb && !bus.ack && !bus.err;

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= mem_pkg::MEM_CLEAR;
			clr_cnt   <= '0;
			init_done <= 1'b0;
			bus.ack   <= 1'b0;
			bus.err   <= 1'b0;
		end else begin
			bus.ack <= 1'b0;
			bus.err <= 1'b0;
			case (state)
				mem_pkg::MEM_CLEAR: begin
					clr_cnt <= clr_cnt + 1'b1;
					if (&clr_cnt) begin // sweep ends at the last word.
						state     <= mem_pkg::MEM_READY;
						init_done <= 1'b1;
					end
				end
				mem_pkg::MEM_READY: begin
					bus.ack <= req && in_range;
					bus.err <= req && !in_range;
				end
				default: state <= mem_pkg::MEM_CLEAR;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == mem_pkg::MEM_CLEAR) begin
			mem[clr_cnt] <= '0;
		end else if (req && in_range && bus.we) begin
			for (int b = 0; b < mem_pkg::SEL_WIDTH; b++) begin
				if (bus.sel[b]) mem[word_idx][8*b +: 8] <= bus.dat_w[8*b +: 8]; // byte lane.
			end
		end
	end

	always_ff @(posedge clk) begin
		if (req && in_range) bus.dat_r <= mem[word_idx];
	end

endmodule

`default_nettype wire

// File: logic/mem_subsystem.sv
`default_nettype none

module mem_subsystem (
	input  logic                                                  clk,
	input  logic                                                  rst,
	input  logic [mem_pkg::NUM_PORTS-1:0][mem_pkg::ADDR_WIDTH-1:0] port_adr,
	input  logic [mem_pkg::NUM_PORTS-1:0][mem_pkg::DATA_WIDTH-1:0] port_dat_w,
	output logic [mem_pkg::NUM_PORTS-1:0][mem_pkg::DATA_WIDTH-1:0] port_dat_r,
	input  logic [mem_pkg::NUM_PORTS-1:0][mem_pkg::SEL_WIDTH-1:0]  port_sel,
	input  logic [mem_pkg::NUM_PORTS-1:0]                         port_we,
	input  logic [mem_pkg::NUM_PORTS-1:0]                         port_cyc,
	input  logic [mem_pkg::NUM_PORTS-1:0]                         port_stb,
	output logic [mem_pkg::NUM_PORTS-1:0]                         port_ack,
	output logic [mem_pkg::NUM_PORTS-1:0]                         port_err,
	output logic [mem_pkg::NUM_PORTS-1:0]                         port_stall,
	output logic                                                  init_done
);

	wb_classic_if bridge_bus [mem_pkg::NUM_PORTS] ();
	wb_classic_if core_bus ();

	for (genvar i = 0; i < mem_pkg::NUM_PORTS; i++) begin : g_bridge
		port_bridge u_bridge (
			.clk      (clk),
			.rst      (rst),
			.in_adr   (port_adr[i]),
			.in_dat_w (port_dat_w[i]),
			.in_sel   (port_sel[i]),
			.in_we    (port_we[i]),
			.in_cyc   (port_cyc[i]),
			.in_stb   (port_stb[i]),
			.stall    (port_stall[i]),
			.ack      (port_ack[i]),
			.err      (port_err[i]),
			.dat_r    (port_dat_r[i]),
			.bus      (bridge_bus[i])
		);
	end

	port_arbiter u_arbiter (
		.clk       (clk),
		.rst       (rst),
		.init_done (init_done),
		.ports     (bridge_bus),
		.core      (core_bus)
	);

	mem_core u_core (
		.clk       (clk),
		.rst       (rst),
		.init_done (init_done),
		.bus       (core_bus)
	);

endmodule

`default_nettype wire

// File: bench/tb_mem_subsystem.sv
`default_nettype none

module tb_mem_subsystem;

	timeunit 1ns;
	timeprecision 1ns;

	typedef logic [$clog2(mem_pkg::NUM_PORTS)-1:0] port_t;
	typedef logic [$clog2(mem_pkg::MEM_WORDS)-1:0] word_t;

	logic clk = 1'b0;
	logic rst;
	logic [mem_pkg::NUM_PORTS-1:0][31:0] port_adr;
	logic [mem_pkg::NUM_PORTS-1:0][31:0] port_dat_w;
	logic [mem_pkg::NUM_PORTS-1:0][31:0] port_dat_r;
	logic [mem_pkg::NUM_PORTS-1:0][3:0]  port_sel;
	logic [mem_pkg::NUM_PORTS-1:0]       port_we;
	logic [mem_pkg::NUM_PORTS-1:0]       port_cyc;
	logic [mem_pkg::NUM_PORTS-1:0]       port_stb;
	logic [mem_pkg::NUM_PORTS-1:0]       port_ack;
	logic [mem_pkg::NUM_PORTS-1:0]       port_err;
	logic [mem_pkg::NUM_PORTS-1:0]       port_stall;
	logic                                init_done;

	logic [31:0] ref_mem [mem_pkg::MEM_WORDS]; // expected memory contents.
	int          cycles = 0;

	mem_subsystem dut (.*);

	always #50 clk = ~clk;

	// clearing sweep plus about 400 transactions of 40 cycles.
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == 20000) begin
			$display("timeout: the DUT did not finish within 20000 cycles");
			$display("tests failed");
			$fatal(1);
		end
	end

	task automatic check_equal(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("error: %s is %h, expected %h", name, actual, expected);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	function automatic logic [31:0] merge_bytes(input logic [31:0] old,
			input logic [31:0] data, input logic [3:0] sel);
		logic [31:0] result;
		result = old;
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) result[8*b +: 8] = data[8*b +: 8];
		end
		return result;
	endfunction

	function automatic logic [31:0] word_addr(input word_t w);
		return 32'(w) << 2;
	endfunction

	task automatic wb_access(input port_t p, input logic [31:0] adr, input logic we,
			input logic [3:0] sel, input logic [31:0] wdata,
			output logic ack_seen, output logic err_seen, output logic [31:0] rdata);
		@(posedge clk);
		port_adr[p]   <= adr;
		port_dat_w[p] <= wdata;
		port_sel[p]   <= sel;
		port_we[p]    <= we;
		port_cyc[p]   <= 1'b1;
		port_stb[p]   <= 1'b1;
		@(posedge clk);
		port_stb[p] <= 1'b0; // accepted on this edge.
		do begin
			@(negedge clk);
		end while (!port_ack[p] && !port_err[p]);
		ack_seen = port_ack[p];
		err_seen = port_err[p];
		rdata = port_dat_r[p];
		@(posedge clk);
		port_cyc[p] <= 1'b0;
	endtask

	task automatic wb_write(input port_t p, input logic [31:0] adr, input logic [3:0] sel,
			input logic [31:0] data, output logic ack_seen, output logic err_seen);
		logic [31:0] unused_data;
		wb_access(p, adr, 1'b1, sel, data, ack_seen, err_seen, unused_data);
	endtask

	task automatic wb_read(input port_t p, input logic [31:0] adr,
			output logic ack_seen, output logic err_seen, output logic [31:0] data);
		wb_access(p, adr, 1'b0, 4'hf, 32'h0, ack_seen, err_seen, data);
	endtask

	task automatic write_and_model(input port_t p, input word_t w, input logic [3:0] sel,
			input logic [31:0] data);
		logic ack_seen;
		logic err_seen;
		wb_write(p, word_addr(w), sel, data, ack_seen, err_seen);
		check_equal("port_err", 32'(err_seen), 32'd0);
		ref_mem[w] = merge_bytes(ref_mem[w], data, sel);
	endtask

	task automatic read_and_check(input port_t p, input word_t w);
		logic        ack_seen;
		logic        err_seen;
		logic [31:0] data;
		wb_read(p, word_addr(w), ack_seen, err_seen, data);
		check_equal("port_err", 32'(err_seen), 32'd0);
		check_equal("port_dat_r", data, ref_mem[w]);
	endtask

	task automatic test_clear();
		@(negedge clk);
		check_equal("port_stall", 32'(port_stall), 32'd0);
		check_equal("port_ack", 32'(port_ack), 32'd0);
		check_equal("port_err", 32'(port_err), 32'd0);
		check_equal("init_done", 32'(init_done), 32'd0);
		while (!init_done) @(negedge clk);
		for (int p = 0; p < mem_pkg::NUM_PORTS; p++) begin
			read_and_check(port_t'(p), word_t'(0));
			read_and_check(port_t'(p), word_t'(1));
			read_and_check(port_t'(p), word_t'(127));
			read_and_check(port_t'(p), word_t'(mem_pkg::MEM_WORDS - 1));
		end
	endtask

	task automatic test_shared();
		write_and_model(port_t'(0), word_t'(16), 4'hf, 32'ha5a5_5a5a);
		read_and_check(port_t'(1), word_t'(16)); // read back through the other port.
	endtask

	task automatic test_byte_lanes();
		write_and_model(port_t'(0), word_t'(80), 4'hf, 32'h1122_3344);
		for (int b = 0; b < 4; b++) begin
			write_and_model(port_t'(b % mem_pkg::NUM_PORTS), word_t'(80), 4'(1 << b), $urandom);
			read_and_check(port_t'(1), word_t'(80));
		end
	endtask

	task automatic test_range_error();
		logic        ack_seen;
		logic        err_seen;
		logic [31:0] data;
		write_and_model(port_t'(1), word_t'(16), 4'hf, 32'h0bad_cafe);
		wb_write(port_t'(0), 32'h0000_0440, 4'hf, 32'hffff_ffff, ack_seen, err_seen);
		check_equal("port_err", 32'(err_seen), 32'd1);
		check_equal("port_ack", 32'(ack_seen), 32'd0);
		wb_read(port_t'(1), 32'h8000_0040, ack_seen, err_seen, data);
		check_equal("port_err", 32'(err_seen), 32'd1);
		check_equal("port_ack", 32'(ack_seen), 32'd0);
		read_and_check(port_t'(0), word_t'(16)); // aliased word unchanged.
	endtask

	task automatic test_contention();
		logic [mem_pkg::NUM_PORTS-1:0] done;
		int                            step;
		done = '0;
		step = 0;
		for (int p = 0; p < mem_pkg::NUM_PORTS; p++) begin
			write_and_model(port_t'(p), word_t'(48 + p), 4'hf, 32'h3000_0000 + p);
		end
		@(posedge clk);
		for (int p = 0; p < mem_pkg::NUM_PORTS; p++) begin
			port_adr[port_t'(p)] <= word_addr(word_t'(48 + p));
			port_we[port_t'(p)]  <= 1'b0;
			port_sel[port_t'(p)] <= 4'hf;
			port_cyc[port_t'(p)] <= 1'b1;
			port_stb[port_t'(p)] <= 1'b1;
		end
		@(posedge clk);
		port_stb <= '0;
		while (done != '1) begin
			@(negedge clk);
			for (int p = 0; p < mem_pkg::NUM_PORTS; p++) begin
				check_equal("port_err", 32'(port_err[p]), 32'd0);
				if (done[p]) begin
					check_equal("port_ack", 32'(port_ack[p]), 32'd0);
				end else begin
					check_equal("port_stall", 32'(port_stall[p]), 32'd1);
					if (port_ack[p]) begin
						check_equal("port_dat_r", port_dat_r[p], ref_mem[word_t'(48 + p)]);
						done[p] = 1'b1;
					end
				end
			end
			@(posedge clk);
			for (int p = 0; p < mem_pkg::NUM_PORTS; p++) begin
				// decoy write that the stalled bridge drops.
				port_stb[port_t'(p)]   <= !done[p] && step[0];
				port_adr[port_t'(p)]   <= word_addr(word_t'(56 + p));
				port_we[port_t'(p)]    <= 1'b1;
				port_dat_w[port_t'(p)] <= 32'hdead_beef;
			end
			step++;
		end
		repeat (4) begin
			@(negedge clk);
			check_equal("port_ack", 32'(port_ack), 32'd0);
			check_equal("port_stall", 32'(port_stall), 32'd0);
		end
		@(posedge clk);
		port_cyc <= '0;
		read_and_check(port_t'(0), word_t'(56));
		read_and_check(port_t'(1), word_t'(57));
	endtask

	task automatic test_random();
		port_t p;
		word_t w;
		for (int n = 0; n < 300; n++) begin
			p = port_t'($urandom % mem_pkg::NUM_PORTS);
			w = word_t'($urandom);
			if ($urandom % 2 == 0) write_and_model(p, w, 4'($urandom), $urandom);
			else read_and_check(p, w);
		end
	endtask

	// words written here must read back as zero after the next sweep.
	task automatic test_reset_clear();
		write_and_model(port_t'(0), word_t'(0), 4'hf, 32'h1234_5678);
		write_and_model(port_t'(1), word_t'(1), 4'hf, 32'h9abc_def0);
		write_and_model(port_t'(0), word_t'(127), 4'hf, 32'h0f0f_0f0f);
		write_and_model(port_t'(1), word_t'(mem_pkg::MEM_WORDS - 1), 4'hf, 32'hf0f0_f0f0);
		@(posedge clk);
		rst <= 1'b1;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		foreach (ref_mem[i]) ref_mem[i] = '0;
		test_clear();
	endtask

	initial begin
		void'($urandom(32'h5d9423d9));
		rst        <= 1'b1;
		port_adr   <= '0;
		port_dat_w <= '0;
		port_sel   <= '0;
		port_we    <= '0;
		port_cyc   <= '0;
		port_stb   <= '0;
		foreach (ref_mem[i]) ref_mem[i] = '0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		test_clear();
		test_shared();
		test_byte_lanes();
		test_range_error();
		test_contention();
		test_random();
		test_reset_clear();
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
logic/mem_pkg.sv
logic/wb_classic_if.sv
logic/port_bridge.sv
logic/port_arbiter.sv
logic/mem_core.sv
logic/mem_subsystem.sv
bench/tb_mem_subsystem.sv

// File: Makefile
# Verilator build of the memory subsystem testbench.

SRCS := $(shell grep -v '^+' build.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_mem_subsystem: build.f $(SRCS)
	verilator --binary --timing -j 0 --top-module tb_mem_subsystem -f build.f

run: obj_dir/Vtb_mem_subsystem
	@out="$$(./obj_dir/Vtb_mem_subsystem)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'all tests passed'

clean:
	rm -rf obj_dir

# the binary is rebuilt only when build.f or a listed source changes.
# run fails unless the pass message appears in the output.
# no log file is written.
# sources come from build.f.
